//--- common/rename_cfg_pkg.sv
`default_nettype none

// Sizing of the renaming stage.
// These are the defaults of the top-level parameters, which pass them down to every block.
package rename_cfg_pkg;

   // Width of an architectural register address.
   // Five bits give 32 registers.
   localparam int W_ADDR = 5;

   // Width of a rename tag.
   // Four bits allow 16 results in flight at once.
   localparam int W_TAG = 4;

   // Width of a data word on the CDB and in the register file.
   localparam int W_DATA = 32;

endpackage

`default_nettype wire

//--- common/rename_msg_pkg.sv
`default_nettype none

// Types carried between the renaming stage and its users.
package rename_msg_pkg;

   // A rename tag, naming the pending producer of a register.
   typedef logic [rename_cfg_pkg::W_TAG-1:0] tag_t;

   // A data word as it travels on the CDB.
   typedef logic [rename_cfg_pkg::W_DATA-1:0] data_t;

   // A source operand word.
   // The ready bit next to it decides how it is read.
   // When ready, the whole word is the value.
   // When not ready, the low bits hold the tag to wait for and the rest is zero.
   typedef union packed {
      data_t value;
      struct packed {
         logic [rename_cfg_pkg::W_DATA-rename_cfg_pkg::W_TAG-1:0] pad;
         tag_t                                                     tag;
      } pend;
   } operand_u;

endpackage

`default_nettype wire

//--- common/dispatch_if.sv
`timescale 1ns/100ps
`default_nettype none

// Dispatch bundle.
// The source strobes valid for one cycle with the destination and two source registers.
// The tag pool answers in the same cycle with the tag that the destination will get.
interface dispatch_if #(
   parameter int W_ADDR = 5,
   parameter int W_TAG  = 4
);

   logic              valid;
   logic [W_ADDR-1:0] rd_addr;
   logic [W_ADDR-1:0] rs_addr;
   logic [W_ADDR-1:0] rt_addr;
   logic [W_TAG-1:0]  tag;

   // The instruction source, which is the top level.
   modport src (output valid, rd_addr, rs_addr, rt_addr, input tag);

   // The tag pool offers the lowest free tag and takes it on valid.
   modport alloc (input valid, output tag);

   // The status table records the new mapping and reads both sources.
   modport status (input valid, rd_addr, rs_addr, rt_addr, tag);

   // The operand selector only needs the source addresses.
   modport reader (input rs_addr, rt_addr);

endinterface

`default_nettype wire

//--- rename/reg_status_table.sv
`timescale 1ns/100ps
`default_nettype none

// Register status table.
// Each architectural register has a valid bit and the tag of its pending producer.
// A clear valid bit means the register file holds the current value.
module reg_status_table #(
   parameter int W_ADDR = rename_cfg_pkg::W_ADDR,
   parameter int W_TAG  = rename_cfg_pkg::W_TAG
) (
   input  logic                 clk,
   input  logic                 rst_n,
   dispatch_if.status           disp,
   input  logic                 cdb_valid,
   input  logic [W_TAG-1:0]     cdb_tag,
   output logic                 rs_valid,
   output logic [W_TAG-1:0]     rs_tag,
   output logic                 rt_valid,
   output logic [W_TAG-1:0]     rt_tag,
   output logic [2**W_ADDR-1:0] regfile_wen_onehot
);

   localparam int N_REG = 2 ** W_ADDR;

   // Pending flags and producer tags, one entry per register.
   logic [N_REG-1:0] valid;
   logic [W_TAG-1:0] tags [N_REG];

   // CAM result, one bit per entry that holds the broadcast tag.
   logic [N_REG-1:0] match;

   // Both source reads are combinational.
   // A dispatch in this cycle is not visible until the next one.
   assign rs_valid = valid[disp.rs_addr];
   assign rs_tag   = tags[disp.rs_addr];
   assign rt_valid = valid[disp.rt_addr];
   assign rt_tag   = tags[disp.rt_addr];

   // Search every valid entry for the tag on the CDB.
   always_comb begin
      for (int i = 0; i < N_REG; i++) begin
         match[i] = cdb_valid && valid[i] && (tags[i] == cdb_tag);
      end
   end

   // The matching register takes the CDB value.
   // This also happens when a dispatch claims that register in the same cycle.
   // The entry then stays pending on the new tag, so the value is never read.
   assign regfile_wen_onehot = match;

   // Dispatch sets the entry and takes priority over a CDB clear of the same register.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
      end else begin
         for (int i = 0; i < N_REG; i++) begin
            if (disp.valid && (disp.rd_addr == W_ADDR'(i))) begin
               valid[i] <= 1'b1;
            end else if (match[i]) begin
               valid[i] <= 1'b0;
            end
         end
      end
   end

   // The tag only matters while the valid bit is set.
   always_ff @(posedge clk) begin
      if (disp.valid) begin
         tags[disp.rd_addr] <= disp.tag;
      end
   end

   // The tag pool never hands out a busy tag, so two live entries cannot share one.
   a_single_match : assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> $onehot0(match))
      else $error("CDB tag %0d matches more than one register", cdb_tag);

   // A broadcast whose register was redispatched finds no entry.
   // This is legal but worth seeing in the log.
   a_tag_found : assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> (|match))
      else $warning("CDB tag %0d matches no pending register", cdb_tag);

endmodule

`default_nettype wire

//--- rename/tag_pool.sv
`timescale 1ns/100ps
`default_nettype none

// Pool of rename tags.
// A busy bit per tag marks results that are still in flight.
module tag_pool #(
   parameter int W_TAG = rename_cfg_pkg::W_TAG
) (
   input  logic             clk,
   input  logic             rst_n,
   dispatch_if.alloc        disp,
   input  logic             cdb_valid,
   input  logic [W_TAG-1:0] cdb_tag,
   output logic             pool_empty
);

   localparam int N_TAG = 2 ** W_TAG;

   logic [N_TAG-1:0] busy;
   logic [W_TAG-1:0] free_tag;

   // Priority encoder that offers the lowest free tag.
   // With every tag busy it falls back to zero, which the source must not use.
   always_comb begin
      free_tag = '0;
      for (int i = N_TAG - 1; i >= 0; i--) begin
         if (!busy[i]) begin
            free_tag = W_TAG'(i);
         end
      end
   end

   assign disp.tag   = free_tag;
   assign pool_empty = &busy;

   // A CDB tag is always busy and the offered tag is always free, so both
   // updates in one cycle touch different bits.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         if (cdb_valid) begin
            busy[cdb_tag] <= 1'b0;
         end
         if (disp.valid) begin
            busy[free_tag] <= 1'b1;
         end
      end
   end

   // The instruction source has to watch pool_empty before it strobes.
   a_no_dispatch_when_empty : assert property (@(posedge clk) disable iff (!rst_n)
      disp.valid |-> !pool_empty)
      else $error("dispatch while the tag pool is empty");

   // Only a tag handed out earlier can come back on the CDB.
   a_cdb_tag_busy : assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> busy[cdb_tag])
      else $error("CDB tag %0d was not in flight", cdb_tag);

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

// Architectural register file.
// It is written only from the CDB, through the one-hot enable of the status table.
module reg_file #(
   parameter int W_ADDR = rename_cfg_pkg::W_ADDR,
   parameter int W_DATA = rename_cfg_pkg::W_DATA
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [2**W_ADDR-1:0] wen_onehot,
   input  logic [W_DATA-1:0]    cdb_data,
   input  logic [W_ADDR-1:0]    rs_addr,
   input  logic [W_ADDR-1:0]    rt_addr,
   output logic [W_DATA-1:0]    rs_value,
   output logic [W_DATA-1:0]    rt_value
);

   localparam int N_REG = 2 ** W_ADDR;

   logic [W_DATA-1:0] regs [N_REG];

   // Every register reads as zero after reset.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < N_REG; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_REG; i++) begin
            if (wen_onehot[i]) begin
               regs[i] <= cdb_data;
            end
         end
      end
   end

   // Two combinational read ports.
   assign rs_value = regs[rs_addr];
   assign rt_value = regs[rt_addr];

   // One CDB result belongs to exactly one register, if any.
   a_wen_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(wen_onehot))
      else $error("register file enable has more than one bit set: %h", wen_onehot);

endmodule

`default_nettype wire

//--- hw/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

// Operand builder for both sources of a dispatched instruction.
// A source is ready with the register value, ready with the CDB value, or waiting on a tag.
module operand_select #(
   parameter int W_TAG  = rename_cfg_pkg::W_TAG,
   parameter int W_DATA = rename_cfg_pkg::W_DATA
) (
   dispatch_if.reader              disp,
   input  logic                    rs_valid,
   input  logic [W_TAG-1:0]        rs_tag,
   input  logic                    rt_valid,
   input  logic [W_TAG-1:0]        rt_tag,
   input  logic [W_DATA-1:0]       rs_value,
   input  logic [W_DATA-1:0]       rt_value,
   input  logic                    cdb_valid,
   input  logic [W_TAG-1:0]        cdb_tag,
   input  logic [W_DATA-1:0]       cdb_data,
   output logic                    rs_ready,
   output rename_msg_pkg::operand_u rs_word,
   output logic                    rt_ready,
   output rename_msg_pkg::operand_u rt_word
);

   import rename_msg_pkg::*;

   // Resolve one source.
   // The CDB bypass covers a result that is broadcast in the same cycle as the read.
   function automatic operand_u pick(input logic pending, input logic [W_TAG-1:0] ptag,
                                     input logic [W_DATA-1:0] value, output logic ready);
      operand_u word;
      word = '0;
      if (!pending) begin
         ready      = 1'b1;
         word.value = data_t'(value);
      end else if (cdb_valid && (cdb_tag == ptag)) begin
         ready      = 1'b1;
         word.value = data_t'(cdb_data);
      end else begin
         ready         = 1'b0;
         word.pend.tag = tag_t'(ptag);
      end
      return word;
   endfunction

   // The source addresses already selected the table and register file entries upstream.
   always_comb begin
      rs_word = pick(rs_valid, rs_tag, rs_value, rs_ready);
      rt_word = pick(rt_valid, rt_tag, rt_value, rt_ready);
   end

endmodule

`default_nettype wire

//--- hw/rename_stage.sv
`timescale 1ns/100ps
`default_nettype none

// Renaming and operand stage.
// Dispatch takes a free tag for the destination and reads both sources in the same cycle.
// The CDB retires a tag, updates the register file and bypasses to the operand reads.
module rename_stage #(
   parameter int W_ADDR = rename_cfg_pkg::W_ADDR,
   parameter int W_TAG  = rename_cfg_pkg::W_TAG,
   parameter int W_DATA = rename_cfg_pkg::W_DATA
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     dispatch_valid,
   input  logic [W_ADDR-1:0]        dispatch_rd,
   input  logic [W_ADDR-1:0]        dispatch_rs,
   input  logic [W_ADDR-1:0]        dispatch_rt,
   input  logic                     cdb_valid,
   input  logic [W_TAG-1:0]         cdb_tag,
   input  logic [W_DATA-1:0]        cdb_data,
   output logic [W_TAG-1:0]         dispatch_tag,
   output logic                     pool_empty,
   output logic                     rs_ready,
   output rename_msg_pkg::operand_u rs_word,
   output logic                     rt_ready,
   output rename_msg_pkg::operand_u rt_word
);

   // Status table outputs toward the operand selector.
   logic              rs_valid;
   logic [W_TAG-1:0]  rs_tag;
   logic              rt_valid;
   logic [W_TAG-1:0]  rt_tag;

   // Register file read data and write enable.
   logic [W_DATA-1:0]   rs_value;
   logic [W_DATA-1:0]   rt_value;
   logic [2**W_ADDR-1:0] regfile_wen_onehot;

   dispatch_if #(.W_ADDR(W_ADDR), .W_TAG(W_TAG)) disp ();

   // The top level is the instruction source of the bundle.
   assign disp.valid   = dispatch_valid;
   assign disp.rd_addr = dispatch_rd;
   assign disp.rs_addr = dispatch_rs;
   assign disp.rt_addr = dispatch_rt;
   assign dispatch_tag = disp.tag;

   reg_status_table #(.W_ADDR(W_ADDR), .W_TAG(W_TAG)) u_status (
      .clk(clk), .rst_n(rst_n), .disp(disp),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
      .rs_valid(rs_valid), .rs_tag(rs_tag), .rt_valid(rt_valid), .rt_tag(rt_tag),
      .regfile_wen_onehot(regfile_wen_onehot)
   );

   tag_pool #(.W_TAG(W_TAG)) u_pool (
      .clk(clk), .rst_n(rst_n), .disp(disp),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .pool_empty(pool_empty)
   );

   reg_file #(.W_ADDR(W_ADDR), .W_DATA(W_DATA)) u_regs (
      .clk(clk), .rst_n(rst_n), .wen_onehot(regfile_wen_onehot), .cdb_data(cdb_data),
      .rs_addr(dispatch_rs), .rt_addr(dispatch_rt),
      .rs_value(rs_value), .rt_value(rt_value)
   );

   operand_select #(.W_TAG(W_TAG), .W_DATA(W_DATA)) u_operands (
      .disp(disp),
      .rs_valid(rs_valid), .rs_tag(rs_tag), .rt_valid(rt_valid), .rt_tag(rt_tag),
      .rs_value(rs_value), .rt_value(rt_value),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
      .rs_ready(rs_ready), .rs_word(rs_word), .rt_ready(rt_ready), .rt_word(rt_word)
   );

endmodule

`default_nettype wire

//--- verification/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

// Clock and reset for the testbench.
// Reset is released on a falling edge so it never races the rising edge.
module clk_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- verification/tb_rename_stage.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the renaming stage.
// A reference model tracks pending tags, busy tags and register values, and
// concurrent assertions compare every DUT output with it on each rising edge.
module tb_rename_stage;

   import rename_cfg_pkg::*;
   import rename_msg_pkg::*;

   localparam int PERIOD_NS = 4;
   localparam int N_REG     = 2 ** W_ADDR;
   localparam int N_TAG     = 2 ** W_TAG;
   localparam int N_RANDOM  = 400;
   // Generous cycle budget per test, drains of the tag pool included.
   localparam int TEST_CYCLES = 2 + 40 + 10 + 30 + 30 + 40 + N_RANDOM + 20;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * PERIOD_NS;

   logic              clk;
   logic              rst_n;
   logic              dispatch_valid;
   logic [W_ADDR-1:0] dispatch_rd;
   logic [W_ADDR-1:0] dispatch_rs;
   logic [W_ADDR-1:0] dispatch_rt;
   logic              cdb_valid;
   tag_t              cdb_tag;
   data_t             cdb_data;
   tag_t              dispatch_tag;
   logic              pool_empty;
   logic              rs_ready;
   operand_u          rs_word;
   logic              rt_ready;
   operand_u          rt_word;

   // Reference model state.
   logic [N_REG-1:0] m_pending;
   tag_t             m_tag [N_REG];
   data_t            m_value [N_REG];
   logic [N_TAG-1:0] m_busy;

   // Expected outputs, derived from the model and the current inputs.
   tag_t     exp_tag;
   logic     exp_empty;
   logic     exp_rs_ready;
   logic     exp_rt_ready;
   operand_u exp_rs_word;
   operand_u exp_rt_word;

   int unsigned seed = 63;
   int errors;
   int errors_at_start;
   int tests_run;
   int tests_failed;

   clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst_n(rst_n));

   rename_stage #(.W_ADDR(W_ADDR), .W_TAG(W_TAG), .W_DATA(W_DATA)) UUT (
      .clk(clk), .rst_n(rst_n),
      .dispatch_valid(dispatch_valid), .dispatch_rd(dispatch_rd),
      .dispatch_rs(dispatch_rs), .dispatch_rt(dispatch_rt),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
      .dispatch_tag(dispatch_tag), .pool_empty(pool_empty),
      .rs_ready(rs_ready), .rs_word(rs_word), .rt_ready(rt_ready), .rt_word(rt_word)
   );

   // Linear congruential generator for all random choices.
   function automatic int unsigned lcg();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed >> 8;
   endfunction

   // A source is ready unless it waits on a tag that is not on the CDB right now.
   // A waiting source carries its tag zero-extended in the operand word.
   function automatic operand_u model_operand(input logic pending, input tag_t ptag,
                                              input data_t value, input logic cv,
                                              input tag_t ctag, input data_t cdata,
                                              output logic ready);
      operand_u word;
      logic     on_cdb;
      on_cdb = cv && (ctag == ptag);
      ready  = !pending || on_cdb;
      word.value = pending ? (on_cdb ? cdata : data_t'(ptag)) : value;
      return word;
   endfunction

   // The pool offers the lowest tag that is not in flight.
   always_comb begin
      exp_tag   = '0;
      exp_empty = 1'b1;
      for (int i = 0; i < N_TAG; i++) begin
         if (exp_empty && !m_busy[i]) begin
            exp_tag   = tag_t'(i);
            exp_empty = 1'b0;
         end
      end
   end

   always_comb begin
      exp_rs_word = model_operand(m_pending[dispatch_rs], m_tag[dispatch_rs],
                                  m_value[dispatch_rs], cdb_valid, cdb_tag, cdb_data,
                                  exp_rs_ready);
      exp_rt_word = model_operand(m_pending[dispatch_rt], m_tag[dispatch_rt],
                                  m_value[dispatch_rt], cdb_valid, cdb_tag, cdb_data,
                                  exp_rt_ready);
   end

   // Model update.
   // The dispatch assignments come last so a dispatch wins over a clear of its register.
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_pending <= '0;
         m_busy    <= '0;
         for (int i = 0; i < N_REG; i++) begin
            m_value[i] <= '0;
         end
      end else begin
         if (cdb_valid) begin
            m_busy[cdb_tag] <= 1'b0;
            for (int i = 0; i < N_REG; i++) begin
               if (m_pending[i] && (m_tag[i] == cdb_tag)) begin
                  m_value[i]   <= cdb_data;
                  m_pending[i] <= 1'b0;
               end
            end
         end
         if (dispatch_valid) begin
            m_pending[dispatch_rd] <= 1'b1;
            m_tag[dispatch_rd]     <= exp_tag;
            m_busy[exp_tag]        <= 1'b1;
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [W_DATA-1:0] expected,
                                  input logic [W_DATA-1:0] actual);
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
   endtask

   a_rs_ready : assert property (@(posedge clk) disable iff (!rst_n)
      rs_ready == exp_rs_ready)
      else report_mismatch("rs_ready", $sampled(exp_rs_ready), $sampled(rs_ready));

   a_rs_word : assert property (@(posedge clk) disable iff (!rst_n)
      rs_word == exp_rs_word)
      else report_mismatch("rs_word", $sampled(exp_rs_word), $sampled(rs_word));

   a_rt_ready : assert property (@(posedge clk) disable iff (!rst_n)
      rt_ready == exp_rt_ready)
      else report_mismatch("rt_ready", $sampled(exp_rt_ready), $sampled(rt_ready));

   a_rt_word : assert property (@(posedge clk) disable iff (!rst_n)
      rt_word == exp_rt_word)
      else report_mismatch("rt_word", $sampled(exp_rt_word), $sampled(rt_word));

   a_pool_empty : assert property (@(posedge clk) disable iff (!rst_n)
      pool_empty == exp_empty)
      else report_mismatch("pool_empty", $sampled(exp_empty), $sampled(pool_empty));

   // The offered tag has no meaning while every tag is in flight.
   a_dispatch_tag : assert property (@(posedge clk) disable iff (!rst_n)
      !exp_empty |-> (dispatch_tag == exp_tag))
      else report_mismatch("dispatch_tag", $sampled(exp_tag), $sampled(dispatch_tag));

   task automatic set_inputs(input logic dv, input logic [W_ADDR-1:0] rd,
                             input logic [W_ADDR-1:0] rs, input logic [W_ADDR-1:0] rt,
                             input logic cv, input tag_t ctag, input data_t cdata);
      dispatch_valid = dv;
      dispatch_rd    = rd;
      dispatch_rs    = rs;
      dispatch_rt    = rt;
      cdb_valid      = cv;
      cdb_tag        = ctag;
      cdb_data       = cdata;
   endtask

   task automatic read_regs(input int rs, input int rt);
      @(negedge clk);
      set_inputs(1'b0, '0, W_ADDR'(rs), W_ADDR'(rt), 1'b0, '0, '0);
   endtask

   task automatic dispatch(input int rd, input int rs, input int rt);
      @(negedge clk);
      set_inputs(1'b1, W_ADDR'(rd), W_ADDR'(rs), W_ADDR'(rt), 1'b0, '0, '0);
   endtask

   // Broadcasts the tag that register r currently waits on, optionally with a dispatch.
   // The tag is looked up after the falling edge so the model is up to date.
   task automatic broadcast_reg(input int r, input data_t data, input int rs, input int rt,
                                input logic dv, input int rd);
      @(negedge clk);
      set_inputs(dv, W_ADDR'(rd), W_ADDR'(rs), W_ADDR'(rt), 1'b1, m_tag[r], data);
   endtask

   // Broadcasts a known tag, optionally with a dispatch.
   task automatic broadcast_tag(input tag_t tag, input data_t data, input int rs,
                                input int rt, input logic dv, input int rd);
      @(negedge clk);
      set_inputs(dv, W_ADDR'(rd), W_ADDR'(rs), W_ADDR'(rt), 1'b1, tag, data);
   endtask

   // Broadcasts every tag in flight, lowest first, until the pool is full again.
   task automatic drain_tags();
      int t;
      @(negedge clk);
      while (m_busy != '0) begin
         t = 0;
         while (!m_busy[t]) t++;
         set_inputs(1'b0, '0, W_ADDR'(lcg()), W_ADDR'(lcg()), 1'b1, tag_t'(t), lcg());
         @(negedge clk);
      end
      set_inputs(1'b0, '0, '0, '0, 1'b0, '0, '0);
   endtask

   task automatic end_test(input string name);
      @(negedge clk);
      set_inputs(1'b0, '0, '0, '0, 1'b0, '0, '0);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      logic dv;
      logic cv;
      tag_t ctag;
      int   start;
      set_inputs(1'b0, '0, '0, '0, 1'b0, '0, '0);
      errors = 0;
      errors_at_start = 0;
      tests_run = 0;
      tests_failed = 0;
      @(posedge rst_n);

      // Every register reads ready with zero.
      for (int i = 0; i < N_REG; i++) read_regs(i, N_REG - 1 - i);
      end_test("after reset");

      // The read in a dispatch cycle still sees the old mapping.
      dispatch(3, 3, 4);
      read_regs(3, 4);
      dispatch(5, 3, 5);
      dispatch(7, 5, 7);
      read_regs(7, 5);
      end_test("dispatch then read");

      // Bypass in the broadcast cycle, register file afterwards, tag reused.
      broadcast_reg(3, 32'h1234_abcd, 3, 5, 1'b0, 0);
      read_regs(3, 3);
      dispatch(9, 3, 9);
      broadcast_reg(5, 32'h0bad_f00d, 5, 7, 1'b0, 0);
      read_regs(5, 9);
      drain_tags();
      end_test("cdb broadcast");

      // A newer producer keeps the register pending after the old tag returns.
      // The pool is full here, so the first producer of register 10 gets tag 0.
      dispatch(10, 0, 0);
      dispatch(10, 10, 10);
      broadcast_tag(tag_t'(0), 32'h5555_aaaa, 10, 10, 1'b0, 0);
      read_regs(10, 10);
      dispatch(11, 10, 11);
      broadcast_reg(11, 32'h7777_0001, 11, 10, 1'b1, 11);
      read_regs(11, 10);
      drain_tags();
      end_test("dispatch wins");

      // Sixteen dispatches fill the pool and one broadcast frees a tag.
      for (int i = 0; i < N_TAG; i++) dispatch(i, lcg() % N_REG, lcg() % N_REG);
      read_regs(0, 15);
      broadcast_reg(5, 32'hcafe_0005, 5, 6, 1'b0, 0);
      read_regs(5, 6);
      drain_tags();
      end_test("pool exhaustion");

      // Decisions are made after the falling edge, when the model has settled.
      for (int n = 0; n < N_RANDOM; n++) begin
         @(negedge clk);
         dv    = !pool_empty && ((lcg() % 4) != 0);
         cv    = 1'b0;
         ctag  = '0;
         start = lcg() % N_TAG;
         if ((lcg() % 3) != 0) begin
            for (int k = 0; k < N_TAG; k++) begin
               if (!cv && m_busy[(start + k) % N_TAG]) begin
                  cv   = 1'b1;
                  ctag = tag_t'((start + k) % N_TAG);
               end
            end
         end
         set_inputs(dv, W_ADDR'(lcg() % 12), W_ADDR'(lcg() % 12), W_ADDR'(lcg() % 12),
                    cv, ctag, lcg());
      end
      drain_tags();
      end_test("random mix");

      $display("Finished %0d tests, %0d failed, %0d errors.", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
common/rename_cfg_pkg.sv
common/rename_msg_pkg.sv
common/dispatch_if.sv
rename/reg_status_table.sv
rename/tag_pool.sv
hw/reg_file.sv
hw/operand_select.sv
hw/rename_stage.sv
verification/clk_gen.sv
verification/tb_rename_stage.sv

//--- Makefile
# Verilator build and run for the renaming stage testbench.
# Every variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_rename_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

# Sources are taken from the file list so that any change triggers a rebuild.
SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the pass message appears on a line of its own.
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
